//--- axi_arbiter.sv
`timescale 1ns/10ps

module axi_arbiter #(
    parameter logic [axi_bus_pkg::addr_w-1:0] uart_base = axi_bus_pkg::uart_base_default
) (
    input  logic                            clk,
    input  logic                            rst,

    // ifu master, read only
    input  logic [axi_bus_pkg::addr_w-1:0]  ifu_araddr,
    input  logic                            ifu_arvalid,
    input  logic                            ifu_rready,
    output logic                            ifu_arready,
    output logic                            ifu_rvalid,
    output logic [axi_bus_pkg::data_w-1:0]  ifu_rdata,

    // lsu master
    input  logic [axi_bus_pkg::addr_w-1:0]  lsu_araddr,
    input  logic                            lsu_arvalid,
    input  logic                            lsu_rready,
    input  logic [axi_bus_pkg::addr_w-1:0]  lsu_awaddr,
    input  logic                            lsu_awvalid,
    input  logic [axi_bus_pkg::data_w-1:0]  lsu_wdata,
    input  logic                            lsu_wvalid,
    input  logic                            lsu_bready,
    output logic                            lsu_arready,
    output logic                            lsu_rvalid,
    output logic [axi_bus_pkg::data_w-1:0]  lsu_rdata,
    output logic                            lsu_awready,
    output logic                            lsu_wready,
    output logic                            lsu_bvalid,

    // sram slave port
    output logic [axi_bus_pkg::addr_w-1:0]  sram_araddr,
    output logic                            sram_arvalid,
    output logic                            sram_rready,
    output logic [axi_bus_pkg::addr_w-1:0]  sram_awaddr,
    output logic                            sram_awvalid,
    output logic [axi_bus_pkg::data_w-1:0]  sram_wdata,
    output logic                            sram_wvalid,
    output logic                            sram_bready,
    input  logic                            sram_arready,
    input  logic                            sram_rvalid,
    input  logic [axi_bus_pkg::data_w-1:0]  sram_rdata,
    input  logic                            sram_awready,
    input  logic                            sram_wready,
    input  logic                            sram_bvalid,

    // uart slave port
    output logic [axi_bus_pkg::addr_w-1:0]  uart_araddr,
    output logic                            uart_arvalid,
    output logic                            uart_rready,
    output logic [axi_bus_pkg::addr_w-1:0]  uart_awaddr,
    output logic                            uart_awvalid,
    output logic [axi_bus_pkg::data_w-1:0]  uart_wdata,
    output logic                            uart_wvalid,
    output logic                            uart_bready,
    input  logic                            uart_arready,
    input  logic                            uart_rvalid,
    input  logic [axi_bus_pkg::data_w-1:0]  uart_rdata,
    input  logic                            uart_awready,
    input  logic                            uart_wready,
    input  logic                            uart_bvalid
);

    localparam logic [axi_bus_pkg::addr_w-1:0] uart_win = 8;  // window size in bytes

    axi_bus_pkg::arb_state_t state;
    axi_bus_pkg::arb_state_t next_state;

    // unsigned offset compare covers both window bounds at once
    function automatic logic in_uart_win(input logic [axi_bus_pkg::addr_w-1:0] addr);
        logic [axi_bus_pkg::addr_w-1:0] off;
        off = addr - uart_base;
        return off < uart_win;
    endfunction

    // grant selection and release
    always_comb begin
        next_state = state;
        case (state)
            axi_bus_pkg::idle: begin
                if (ifu_arvalid) begin
                    next_state = axi_bus_pkg::ifu_rd;  // fetch wins
                end else if (lsu_arvalid) begin
                    next_state = in_uart_win(lsu_araddr) ? axi_bus_pkg::lsu_rd_uart
                                                         : axi_bus_pkg::lsu_rd_sram;
                end else if (lsu_awvalid && lsu_wvalid) begin
                    next_state = in_uart_win(lsu_awaddr) ? axi_bus_pkg::lsu_wr_uart
                                                         : axi_bus_pkg::lsu_wr_sram;
                end
            end
            axi_bus_pkg::ifu_rd:      if (sram_rvalid && ifu_rready) next_state = axi_bus_pkg::idle;
            axi_bus_pkg::lsu_rd_sram: if (sram_rvalid && lsu_rready) next_state = axi_bus_pkg::idle;
            axi_bus_pkg::lsu_rd_uart: if (uart_rvalid && lsu_rready) next_state = axi_bus_pkg::idle;
            axi_bus_pkg::lsu_wr_sram: if (sram_bvalid && lsu_bready) next_state = axi_bus_pkg::idle;
            axi_bus_pkg::lsu_wr_uart: if (uart_bvalid && lsu_bready) next_state = axi_bus_pkg::idle;
            default:                  next_state = axi_bus_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= axi_bus_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // channel routing, everything quiet unless the state connects it
    always_comb begin
        ifu_arready  = 1'b0;
        ifu_rvalid   = 1'b0;
        ifu_rdata    = '0;
        lsu_arready  = 1'b0;
        lsu_rvalid   = 1'b0;
        lsu_rdata    = '0;
        lsu_awready  = 1'b0;
        lsu_wready   = 1'b0;
        lsu_bvalid   = 1'b0;
        sram_araddr  = '0;
        sram_arvalid = 1'b0;
        sram_rready  = 1'b0;
        sram_awaddr  = '0;
        sram_awvalid = 1'b0;
        sram_wdata   = '0;
        sram_wvalid  = 1'b0;
        sram_bready  = 1'b0;
        uart_araddr  = '0;
        uart_arvalid = 1'b0;
        uart_rready  = 1'b0;
        uart_awaddr  = '0;
        uart_awvalid = 1'b0;
        uart_wdata   = '0;
        uart_wvalid  = 1'b0;
        uart_bready  = 1'b0;
        case (state)
            axi_bus_pkg::ifu_rd: begin
                sram_araddr  = ifu_araddr;
                sram_arvalid = ifu_arvalid;
                ifu_arready  = sram_arready;
                sram_rready  = ifu_rready;
                ifu_rvalid   = sram_rvalid;
                ifu_rdata    = sram_rdata;
            end
            axi_bus_pkg::lsu_rd_sram: begin
                sram_araddr  = lsu_araddr;
                sram_arvalid = lsu_arvalid;
                lsu_arready  = sram_arready;
                sram_rready  = lsu_rready;
                lsu_rvalid   = sram_rvalid;
                lsu_rdata    = sram_rdata;
            end
            axi_bus_pkg::lsu_rd_uart: begin
                uart_araddr  = lsu_araddr;
                uart_arvalid = lsu_arvalid;
                lsu_arready  = uart_arready;
                uart_rready  = lsu_rready;
                lsu_rvalid   = uart_rvalid;
                lsu_rdata    = uart_rdata;
            end
            axi_bus_pkg::lsu_wr_sram: begin
                sram_awaddr  = lsu_awaddr;
                sram_awvalid = lsu_awvalid;
                lsu_awready  = sram_awready;
                sram_wdata   = lsu_wdata;
                sram_wvalid  = lsu_wvalid;
                lsu_wready   = sram_wready;
                sram_bready  = lsu_bready;
                lsu_bvalid   = sram_bvalid;
            end
            axi_bus_pkg::lsu_wr_uart: begin
                uart_awaddr  = lsu_awaddr;
                uart_awvalid = lsu_awvalid;
                lsu_awready  = uart_awready;
                uart_wdata   = lsu_wdata;
                uart_wvalid  = lsu_wvalid;
                lsu_wready   = uart_wready;
                uart_bready  = lsu_bready;
                lsu_bvalid   = uart_bvalid;
            end
            default: ;  // idle
        endcase
    end

endmodule

//--- axi_bus_pkg.sv
package axi_bus_pkg;

    // bus widths shared by masters, arbiter and slaves
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // address map defaults
    // 8-byte uart window: +0 tx data, +4 sent-byte count
    localparam logic [addr_w-1:0] uart_base_default = 32'ha000_03f8;
    localparam int sram_words_default = 1024;  // 32-bit words, 4 KiB

    // arbiter grant state: who owns the bus and which slave it talks to
    // ifu only fetches, so its reads always go to sram
    typedef enum logic [2:0] {
        idle,
        ifu_rd,
        lsu_rd_sram,
        lsu_rd_uart,
        lsu_wr_sram,
        lsu_wr_uart
    } arb_state_t;

endpackage

//--- mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem #(
    parameter logic [axi_bus_pkg::addr_w-1:0] uart_base  = axi_bus_pkg::uart_base_default,
    parameter int                             sram_words = axi_bus_pkg::sram_words_default
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic [axi_bus_pkg::addr_w-1:0]  ifu_araddr,
    input  logic                            ifu_arvalid,
    input  logic                            ifu_rready,
    output logic                            ifu_arready,
    output logic                            ifu_rvalid,
    output logic [axi_bus_pkg::data_w-1:0]  ifu_rdata,

    input  logic [axi_bus_pkg::addr_w-1:0]  lsu_araddr,
    input  logic                            lsu_arvalid,
    input  logic                            lsu_rready,
    input  logic [axi_bus_pkg::addr_w-1:0]  lsu_awaddr,
    input  logic                            lsu_awvalid,
    input  logic [axi_bus_pkg::data_w-1:0]  lsu_wdata,
    input  logic                            lsu_wvalid,
    input  logic                            lsu_bready,
    output logic                            lsu_arready,
    output logic                            lsu_rvalid,
    output logic [axi_bus_pkg::data_w-1:0]  lsu_rdata,
    output logic                            lsu_awready,
    output logic                            lsu_wready,
    output logic                            lsu_bvalid,

    output logic [7:0]                      tx_byte,
    output logic                            tx_strobe
);

    // arbiter to sram
    logic [axi_bus_pkg::addr_w-1:0] sram_araddr, sram_awaddr;
    logic [axi_bus_pkg::data_w-1:0] sram_wdata, sram_rdata;
    logic sram_arvalid, sram_rready, sram_awvalid, sram_wvalid, sram_bready;
    logic sram_arready, sram_rvalid, sram_awready, sram_wready, sram_bvalid;

    // arbiter to uart
    logic [axi_bus_pkg::addr_w-1:0] uart_araddr, uart_awaddr;
    logic [axi_bus_pkg::data_w-1:0] uart_wdata, uart_rdata;
    logic uart_arvalid, uart_rready, uart_awvalid, uart_wvalid, uart_bready;
    logic uart_arready, uart_rvalid, uart_awready, uart_wready, uart_bvalid;

    axi_arbiter #(
        .uart_base (uart_base)
    ) axi_arbiter_inst (
        .clk          (clk),
        .rst          (rst),
        .ifu_araddr   (ifu_araddr),
        .ifu_arvalid  (ifu_arvalid),
        .ifu_rready   (ifu_rready),
        .ifu_arready  (ifu_arready),
        .ifu_rvalid   (ifu_rvalid),
        .ifu_rdata    (ifu_rdata),
        .lsu_araddr   (lsu_araddr),
        .lsu_arvalid  (lsu_arvalid),
        .lsu_rready   (lsu_rready),
        .lsu_awaddr   (lsu_awaddr),
        .lsu_awvalid  (lsu_awvalid),
        .lsu_wdata    (lsu_wdata),
        .lsu_wvalid   (lsu_wvalid),
        .lsu_bready   (lsu_bready),
        .lsu_arready  (lsu_arready),
        .lsu_rvalid   (lsu_rvalid),
        .lsu_rdata    (lsu_rdata),
        .lsu_awready  (lsu_awready),
        .lsu_wready   (lsu_wready),
        .lsu_bvalid   (lsu_bvalid),
        .sram_araddr  (sram_araddr),
        .sram_arvalid (sram_arvalid),
        .sram_rready  (sram_rready),
        .sram_awaddr  (sram_awaddr),
        .sram_awvalid (sram_awvalid),
        .sram_wdata   (sram_wdata),
        .sram_wvalid  (sram_wvalid),
        .sram_bready  (sram_bready),
        .sram_arready (sram_arready),
        .sram_rvalid  (sram_rvalid),
        .sram_rdata   (sram_rdata),
        .sram_awready (sram_awready),
        .sram_wready  (sram_wready),
        .sram_bvalid  (sram_bvalid),
        .uart_araddr  (uart_araddr),
        .uart_arvalid (uart_arvalid),
        .uart_rready  (uart_rready),
        .uart_awaddr  (uart_awaddr),
        .uart_awvalid (uart_awvalid),
        .uart_wdata   (uart_wdata),
        .uart_wvalid  (uart_wvalid),
        .uart_bready  (uart_bready),
        .uart_arready (uart_arready),
        .uart_rvalid  (uart_rvalid),
        .uart_rdata   (uart_rdata),
        .uart_awready (uart_awready),
        .uart_wready  (uart_wready),
        .uart_bvalid  (uart_bvalid)
    );

    sram_slave #(
        .sram_words (sram_words)
    ) sram_slave_inst (
        .clk     (clk),
        .rst     (rst),
        .araddr  (sram_araddr),
        .arvalid (sram_arvalid),
        .rready  (sram_rready),
        .awaddr  (sram_awaddr),
        .awvalid (sram_awvalid),
        .wdata   (sram_wdata),
        .wvalid  (sram_wvalid),
        .bready  (sram_bready),
        .arready (sram_arready),
        .rvalid  (sram_rvalid),
        .rdata   (sram_rdata),
        .awready (sram_awready),
        .wready  (sram_wready),
        .bvalid  (sram_bvalid)
    );

    uart_slave uart_slave_inst (
        .clk       (clk),
        .rst       (rst),
        .araddr    (uart_araddr),
        .arvalid   (uart_arvalid),
        .rready    (uart_rready),
        .awaddr    (uart_awaddr),
        .awvalid   (uart_awvalid),
        .wdata     (uart_wdata),
        .wvalid    (uart_wvalid),
        .bready    (uart_bready),
        .arready   (uart_arready),
        .rvalid    (uart_rvalid),
        .rdata     (uart_rdata),
        .awready   (uart_awready),
        .wready    (uart_wready),
        .bvalid    (uart_bvalid),
        .tx_byte   (tx_byte),
        .tx_strobe (tx_strobe)
    );

endmodule

//--- mem_subsystem_asserts.sv
`timescale 1ns/10ps

module mem_subsystem_asserts (
    input logic                            clk,
    input logic                            rst,
    input axi_bus_pkg::arb_state_t         state,
    input logic                            sram_arvalid,
    input logic                            uart_arvalid,
    input logic                            sram_awvalid,
    input logic                            uart_awvalid,
    input logic                            sram_rvalid,
    input logic                            sram_bvalid,
    input logic                            uart_rvalid,
    input logic                            uart_bvalid,
    input logic                            ifu_arready,
    input logic                            ifu_rvalid,
    input logic                            ifu_rready,
    input logic [axi_bus_pkg::data_w-1:0]  ifu_rdata,
    input logic                            lsu_arready,
    input logic                            lsu_rvalid,
    input logic                            lsu_rready,
    input logic [axi_bus_pkg::data_w-1:0]  lsu_rdata,
    input logic                            lsu_awready,
    input logic                            lsu_wready,
    input logic                            lsu_bvalid,
    input logic                            lsu_bready
);

    // only one slave addressed or answering a read at a time
    no_double_ar: assert property (@(posedge clk) disable iff (rst)
        !((sram_arvalid || sram_rvalid) && (uart_arvalid || uart_rvalid)))
        else $error("arvalid seen by both slaves");

    ifu_r_hold: assert property (@(posedge clk) disable iff (rst)
        ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata))
        else $error("ifu read response not held until rready");

    lsu_r_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata))
        else $error("lsu read response not held until rready");

    lsu_b_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_bvalid && !lsu_bready |=> lsu_bvalid)
        else $error("lsu write response not held until bready");

    // slave responses consumed before the grant is released
    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        state == axi_bus_pkg::idle |-> !(ifu_arready || ifu_rvalid || lsu_arready
            || lsu_rvalid || lsu_awready || lsu_wready || lsu_bvalid
            || sram_arvalid || uart_arvalid || sram_awvalid || uart_awvalid
            || sram_rvalid || sram_bvalid || uart_rvalid || uart_bvalid))
        else $error("arbiter drives a channel while idle");

endmodule

bind axi_arbiter mem_subsystem_asserts mem_subsystem_asserts_inst (
    .clk          (clk),
    .rst          (rst),
    .state        (state),
    .sram_arvalid (sram_arvalid),
    .uart_arvalid (uart_arvalid),
    .sram_awvalid (sram_awvalid),
    .uart_awvalid (uart_awvalid),
    .sram_rvalid  (sram_rvalid),
    .sram_bvalid  (sram_bvalid),
    .uart_rvalid  (uart_rvalid),
    .uart_bvalid  (uart_bvalid),
    .ifu_arready  (ifu_arready),
    .ifu_rvalid   (ifu_rvalid),
    .ifu_rready   (ifu_rready),
    .ifu_rdata    (ifu_rdata),
    .lsu_arready  (lsu_arready),
    .lsu_rvalid   (lsu_rvalid),
    .lsu_rready   (lsu_rready),
    .lsu_rdata    (lsu_rdata),
    .lsu_awready  (lsu_awready),
    .lsu_wready   (lsu_wready),
    .lsu_bvalid   (lsu_bvalid),
    .lsu_bready   (lsu_bready)
);

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_mem_subsystem -f tb.f -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

//--- sram_slave.sv
`timescale 1ns/10ps

module sram_slave #(
    parameter int sram_words = axi_bus_pkg::sram_words_default
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [axi_bus_pkg::addr_w-1:0]  araddr,
    input  logic                            arvalid,
    input  logic                            rready,
    input  logic [axi_bus_pkg::addr_w-1:0]  awaddr,
    input  logic                            awvalid,
    input  logic [axi_bus_pkg::data_w-1:0]  wdata,
    input  logic                            wvalid,
    input  logic                            bready,
    output logic                            arready,
    output logic                            rvalid,
    output logic [axi_bus_pkg::data_w-1:0]  rdata,
    output logic                            awready,
    output logic                            wready,
    output logic                            bvalid
);

    // depth is taken as a power of two, so slicing wraps the index
    localparam int idx_w = (sram_words > 1) ? $clog2(sram_words) : 1;

    logic [axi_bus_pkg::data_w-1:0] mem [sram_words];

    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;
    logic             ar_fire;
    logic             aw_fire;

    assign rd_idx = araddr[idx_w+1:2];  // byte address to word index
    assign wr_idx = awaddr[idx_w+1:2];

    assign arready = !rvalid;  // one read outstanding at most
    assign ar_fire = arvalid && arready;

    // aw and w accepted together, never while a response waits
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign aw_fire = awready;

    // read response
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;  // handshake done
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= mem[rd_idx];  // held until the next ar
        end
    end

    // write response
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (aw_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            mem[wr_idx] <= wdata;
        end
    end

endmodule

//--- tb.f
axi_bus_pkg.sv
axi_arbiter.sv
sram_slave.sv
uart_slave.sv
mem_subsystem.sv
mem_subsystem_asserts.sv
tb_mem_subsystem.sv

//--- tb_mem_subsystem.sv
`timescale 1ns/10ps

module tb_mem_subsystem;

    localparam logic [31:0] uart_base  = axi_bus_pkg::uart_base_default;
    localparam int          sram_words = axi_bus_pkg::sram_words_default;
    localparam int          n_trans    = 80;  // bus transactions issued below
    localparam int          wait_max   = 40;  // cycles allowed per response

    logic        clk;
    logic        rst;
    logic [31:0] ifu_araddr;
    logic        ifu_arvalid;
    logic        ifu_rready;
    logic        ifu_arready;
    logic        ifu_rvalid;
    logic [31:0] ifu_rdata;
    logic [31:0] lsu_araddr;
    logic        lsu_arvalid;
    logic        lsu_rready;
    logic [31:0] lsu_awaddr;
    logic        lsu_awvalid;
    logic [31:0] lsu_wdata;
    logic        lsu_wvalid;
    logic        lsu_bready;
    logic        lsu_arready;
    logic        lsu_rvalid;
    logic [31:0] lsu_rdata;
    logic        lsu_awready;
    logic        lsu_wready;
    logic        lsu_bvalid;
    logic [7:0]  tx_byte;
    logic        tx_strobe;

    int          errors = 0;
    logic [31:0] lfsr = 32'hb851_5494;
    logic [31:0] ref_mem [sram_words];  // expected sram contents
    int          written [$];           // word indices holding known data
    logic [7:0]  exp_bytes [$];
    logic [7:0]  got_bytes [$];

    mem_subsystem #(
        .uart_base  (uart_base),
        .sram_words (sram_words)
    ) mem_subsystem_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // bytes leaving the uart, in order
    always @(posedge clk) begin
        if (!rst && tx_strobe) got_bytes.push_back(tx_byte);
    end

    initial begin
        #(n_trans * wait_max * 8 + 800);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] word_addr(input int idx);
        return {20'd0, idx[9:0], 2'b00};
    endfunction

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s returned 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data,
                             input int stall);
        int n;
        n = 0;
        @(posedge clk);
        lsu_awaddr  <= addr;
        lsu_wdata   <= data;
        lsu_awvalid <= 1'b1;
        lsu_wvalid  <= 1'b1;
        lsu_bready  <= 1'b0;
        forever begin
            @(posedge clk);
            n++;
            if (lsu_awready && lsu_wready) begin
                lsu_awvalid <= 1'b0;
                lsu_wvalid  <= 1'b0;
            end
            if (lsu_bvalid) break;
            if (n > wait_max) begin
                $display("lsu write to 0x%08h got no bvalid", addr);
                errors++;
                lsu_awvalid <= 1'b0;
                lsu_wvalid  <= 1'b0;
                return;
            end
        end
        // bready held low for the stall, bvalid must stay up
        for (int i = 0; i <= stall; i++) begin
            if (i == stall) lsu_bready <= 1'b1;
            @(posedge clk);
            if (!lsu_bvalid) begin
                errors++;
                $display("Error at %0t: lsu bvalid dropped before bready", $time);
            end
        end
        lsu_bready <= 1'b0;
    endtask

    // lat counts edges from the arvalid drive edge to rvalid seen high
    task automatic lsu_read(input logic [31:0] addr, input int stall,
                            output logic [31:0] data, output int lat);
        int n;
        n = 0;
        data = '0;
        @(posedge clk);
        lsu_araddr  <= addr;
        lsu_arvalid <= 1'b1;
        lsu_rready  <= 1'b0;
        forever begin
            @(posedge clk);
            n++;
            if (lsu_arready) lsu_arvalid <= 1'b0;
            if (lsu_rvalid) break;
            if (n > wait_max) begin
                $display("lsu read of 0x%08h got no rvalid", addr);
                errors++;
                lsu_arvalid <= 1'b0;
                lat = n;
                return;
            end
        end
        lat  = n;
        data = lsu_rdata;
        for (int i = 0; i <= stall; i++) begin
            if (i == stall) lsu_rready <= 1'b1;
            @(posedge clk);
            if (!lsu_rvalid || lsu_rdata !== data) begin
                errors++;
                $display("Error at %0t: lsu rvalid or rdata changed before rready", $time);
            end
        end
        lsu_rready <= 1'b0;
    endtask

    task automatic ifu_read(input logic [31:0] addr, input int stall,
                            output logic [31:0] data, output int lat);
        int n;
        n = 0;
        data = '0;
        @(posedge clk);
        ifu_araddr  <= addr;
        ifu_arvalid <= 1'b1;
        ifu_rready  <= 1'b0;
        forever begin
            @(posedge clk);
            n++;
            if (ifu_arready) ifu_arvalid <= 1'b0;
            if (ifu_rvalid) break;
            if (n > wait_max) begin
                $display("ifu read of 0x%08h got no rvalid", addr);
                errors++;
                ifu_arvalid <= 1'b0;
                lat = n;
                return;
            end
        end
        lat  = n;
        data = ifu_rdata;
        for (int i = 0; i <= stall; i++) begin
            if (i == stall) ifu_rready <= 1'b1;
            @(posedge clk);
            if (!ifu_rvalid || ifu_rdata !== data) begin
                errors++;
                $display("Error at %0t: ifu rvalid or rdata changed before rready", $time);
            end
        end
        ifu_rready <= 1'b0;
    endtask

    task automatic test_reset_state();
        @(posedge clk);
        if (ifu_arready || ifu_rvalid || lsu_arready || lsu_rvalid || lsu_awready
            || lsu_wready || lsu_bvalid || tx_strobe) begin
            errors++;
            $display("Error at %0t: bus outputs not quiet after reset", $time);
        end
    endtask

    task automatic test_sram_write_read();
        int          idx;
        int          lat;
        logic [31:0] data;
        for (int i = 0; i < 16; i++) begin
            idx  = rand_bits(10);
            data = rand_bits(32);
            lsu_write(word_addr(idx), data, 0);
            ref_mem[idx] = data;
            written.push_back(idx);
        end
        foreach (written[i]) begin
            lsu_read(word_addr(written[i]), 0, data, lat);
            compare_word($sformatf("lsu read 0x%08h", word_addr(written[i])),
                         data, ref_mem[written[i]]);
            if (lat != 3) begin
                errors++;
                $display("Error at %0t: lsu read latency %0d, expected 3", $time, lat);
            end
        end
    endtask

    task automatic test_ifu_read();
        int          lat;
        logic [31:0] data;
        for (int i = 0; i < 8; i++) begin
            ifu_read(word_addr(written[i]), 0, data, lat);
            compare_word($sformatf("ifu read 0x%08h", word_addr(written[i])),
                         data, ref_mem[written[i]]);
        end
    endtask

    // both masters ask in the same cycle, fetch must win
    task automatic test_contention();
        int          a;
        int          b;
        int          ifu_lat;
        int          lsu_lat;
        logic [31:0] ifu_data;
        logic [31:0] lsu_data;
        for (int i = 0; i < 4; i++) begin
            a = written[i];
            b = written[15 - i];
            fork
                ifu_read(word_addr(a), 0, ifu_data, ifu_lat);
                lsu_read(word_addr(b), 0, lsu_data, lsu_lat);
            join
            compare_word("contended ifu read", ifu_data, ref_mem[a]);
            compare_word("contended lsu read", lsu_data, ref_mem[b]);
            if (ifu_lat >= lsu_lat) begin
                errors++;
                $display("Error at %0t: lsu rvalid came no later than ifu rvalid", $time);
            end
        end
    endtask

    task automatic test_uart();
        int          lat;
        logic [31:0] data;
        for (int i = 0; i < 6; i++) begin
            data = rand_bits(32);
            lsu_write(uart_base, data, 0);
            exp_bytes.push_back(data[7:0]);
        end
        if (got_bytes.size() != exp_bytes.size()) begin
            errors++;
            $display("Error at %0t: %0d uart bytes seen, expected %0d",
                     $time, got_bytes.size(), exp_bytes.size());
        end
        foreach (exp_bytes[i]) begin
            if (i < got_bytes.size() && got_bytes[i] !== exp_bytes[i]) begin
                errors++;
                $display("Error at %0t: uart byte %0d is 0x%02h, expected 0x%02h",
                         $time, i, got_bytes[i], exp_bytes[i]);
            end
        end
        lsu_read(uart_base + 32'd4, 0, data, lat);
        compare_word("uart count read", data, 32'd6);
        lsu_read(uart_base, 0, data, lat);
        compare_word("uart data read", data, {24'd0, exp_bytes[5]});
    endtask

    task automatic test_stalls();
        int          idx;
        int          lat;
        logic [31:0] data;
        for (int i = 0; i < 12; i++) begin
            idx  = rand_bits(10);
            data = rand_bits(32);
            lsu_write(word_addr(idx), data, rand_bits(3));
            ref_mem[idx] = data;
            lsu_read(word_addr(idx), rand_bits(3), data, lat);
            compare_word($sformatf("stalled lsu read 0x%08h", word_addr(idx)),
                         data, ref_mem[idx]);
        end
    endtask

    initial begin
        rst         <= 1'b1;
        ifu_araddr  <= '0;
        ifu_arvalid <= 1'b0;
        ifu_rready  <= 1'b0;
        lsu_araddr  <= '0;
        lsu_arvalid <= 1'b0;
        lsu_rready  <= 1'b0;
        lsu_awaddr  <= '0;
        lsu_awvalid <= 1'b0;
        lsu_wdata   <= '0;
        lsu_wvalid  <= 1'b0;
        lsu_bready  <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_reset_state();
        test_sram_write_read();
        test_ifu_read();
        test_contention();
        test_uart();
        test_stalls();

        repeat (4) @(posedge clk);
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- uart_slave.sv
`timescale 1ns/10ps

module uart_slave (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [axi_bus_pkg::addr_w-1:0]  araddr,
    input  logic                            arvalid,
    input  logic                            rready,
    input  logic [axi_bus_pkg::addr_w-1:0]  awaddr,
    input  logic                            awvalid,
    input  logic [axi_bus_pkg::data_w-1:0]  wdata,
    input  logic                            wvalid,
    input  logic                            bready,
    output logic                            arready,
    output logic                            rvalid,
    output logic [axi_bus_pkg::data_w-1:0]  rdata,
    output logic                            awready,
    output logic                            wready,
    output logic                            bvalid,
    output logic [7:0]                      tx_byte,
    output logic                            tx_strobe
);

    logic [7:0]  tx_data;    // last byte sent
    logic [31:0] sent_cnt;
    logic        ar_fire;

    assign arready = !rvalid;
    assign ar_fire = arvalid && arready;

    // same accept rule as the sram
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;

    // byte leaves in the cycle of the aw/w transfer, offset 4 is read only
    assign tx_strobe = awready && !awaddr[2];
    assign tx_byte   = wdata[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
            sent_cnt <= '0;
        end else begin
            if (ar_fire)     rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
            if (awready)     bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (tx_strobe)   sent_cnt <= sent_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_strobe) tx_data <= tx_byte;
        if (ar_fire) begin
            rdata <= araddr[2] ? sent_cnt : {24'd0, tx_data};  // bit 2 picks the count
        end
    end

endmodule
